// File: Bender.yml
package:
  name: bpu

sources:
  - files:
      - verilog/bpuPkg.sv
      - verilog/branchTargetCalc.sv
      - verilog/directionPredictor.sv
      - verilog/branchHistoryQueue.sv
      - verilog/redirectArbiter.sv
      - verilog/bpuTop.sv
  - target: test
    files:
      - testbench/bpuTop_checker.sv
      - testbench/bpuTb.sv

// File: project.f
verilog/bpuPkg.sv
verilog/branchTargetCalc.sv
verilog/directionPredictor.sv
verilog/branchHistoryQueue.sv
verilog/redirectArbiter.sv
verilog/bpuTop.sv
testbench/bpuTop_checker.sv
testbench/bpuTb.sv

// File: testbench/bpuTb.sv
`timescale 1ns/1ns

module bpuTb
    import bpuPkg::*;
;

    localparam int queueDepth = 4; // Matches the DUT instance

    logic  clk;
    logic  rstN;
    addrT  pcF;
    instrT instr;
    logic  instrValid;
    logic  resolveValid;
    logic  actualTaken;
    logic  stallFetch;
    logic  predRedirect;
    logic  flush;
    addrT  pcRedirect;

    int        errors;        // Failed checks
    int        checks;        // All checks
    integer    seed;          // $random state
    ctrT       modelFwd;      // Model forward counter
    ctrT       modelBwd;      // Model backward counter
    branchRecT modelQ [$];    // Model in-flight branches, oldest first

    bpuTop #(
        .queueDepth (queueDepth)
    ) dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .pcF          (pcF),
        .instr        (instr),
        .instrValid   (instrValid),
        .resolveValid (resolveValid),
        .actualTaken  (actualTaken),
        .stallFetch   (stallFetch),
        .predRedirect (predRedirect),
        .flush        (flush),
        .pcRedirect   (pcRedirect)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // B-type encoding of a byte offset, rs1 = x1, rs2 = x2
    function automatic instrT makeBranch(input addrT off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // One saturating move of a model counter
    function automatic ctrT moveCtr(input ctrT c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // One sampled cycle, one idle cycle, then compare against the model
    task automatic step(input logic v, input instrT iw, input addrT pc, input addrT off,
                        input logic res, input logic tk);
        logic      isBr;
        logic      stall;
        logic      pop;
        logic      mis;
        logic      pt;
        logic      acc;
        addrT      expPc;
        branchRecT head;
        @(posedge clk);
        instrValid   <= v;
        instr        <= iw;
        pcF          <= pc;
        resolveValid <= res;
        actualTaken  <= tk;
        isBr  = v && (iw[6:0] == 7'b1100011) && (iw[14:12] != 3'b010)
                && (iw[14:12] != 3'b011); // 010 and 011 are no compare
        stall = (modelQ.size() == queueDepth); // Idle edge before makes stall equal full
        pop   = res && (modelQ.size() > 0);
        head  = pop ? modelQ[0] : '0;
        mis   = pop && (tk != head.predTaken);
        pt    = off[31] ? modelBwd[1] : modelFwd[1]; // Prediction from old counter
        acc   = isBr && !stall && !mis;              // Wrong-path and stalled dropped
        expPc = mis ? (tk ? head.target : head.fallThrough) : pc + off;
        if (pop && head.backward) begin
            modelBwd = moveCtr(modelBwd, !mis);
        end else if (pop) begin
            modelFwd = moveCtr(modelFwd, !mis);
        end
        if (mis) begin
            modelQ.delete(); // Younger branches squashed
        end else begin
            if (pop) begin
                void'(modelQ.pop_front());
            end
            if (acc) begin
                modelQ.push_back('{fallThrough: pc + 32'd4, target: pc + off,
                                   backward: off[31], predTaken: pt});
            end
        end
        @(posedge clk);               // DUT samples the inputs here
        instrValid   <= 1'b0;
        resolveValid <= 1'b0;
        @(negedge clk);               // Registered outputs settled
        checkEq(predRedirect, acc && pt, "predRedirect");
        checkEq(flush, mis, "flush");
        checkEq(stallFetch, stall, "stallFetch");
        if (mis || (acc && pt)) begin
            checkEq(pcRedirect, expPc, "pcRedirect");
        end
    endtask

    task automatic presentBranch(input addrT pc, input addrT off);
        step(1'b1, makeBranch(off, 3'b000), pc, off, 1'b0, 1'b0);
    endtask

    task automatic resolveHead(input logic wrong);
        if (modelQ.size() == 0) begin
            errors++;
            $display("test tried to resolve a branch while none was in flight");
        end else begin
            step(1'b0, '0, '0, '0, 1'b1, modelQ[0].predTaken ^ wrong);
        end
    endtask

    task automatic drainQueue();
        while (modelQ.size() > 0) begin
            resolveHead(1'b0);
        end
    endtask

    task automatic waitStall(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (stallFetch !== level && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (stallFetch !== level) begin
            errors++;
            $display("timeout while waiting for stallFetch to become %0b", level);
        end
    endtask

    task automatic testAfterReset();
        presentBranch(32'h0000_0100, 32'h0000_0040); // Forward, weakly not taken
        checkEq(predRedirect, 1'b0, "forward branch after reset");
        presentBranch(32'h0000_0200, -32'sd32);      // Backward, weakly taken
        checkEq(predRedirect, 1'b1, "backward branch after reset");
        checkEq(pcRedirect, 32'h0000_01e0, "backward target after reset");
        step(1'b1, 32'h00a0_0093, 32'h0000_0300, '0, 1'b0, 1'b0); // addi
        step(1'b1, makeBranch(32'h10, 3'b010), 32'h0000_0304, 32'h10, 1'b0, 1'b0);
        drainQueue();
    endtask

    task automatic testResolve();
        presentBranch(32'h0000_1000, -32'sd64);
        resolveHead(1'b0);                           // Correct, no flush
        presentBranch(32'h0000_1100, 32'h0000_0080);
        resolveHead(1'b1);                           // Wrong
        presentBranch(32'h0000_1200, 32'h0000_0100);
        resolveHead(1'b1);                           // Wrong, other direction
    endtask

    task automatic testTraining();
        repeat (6) begin                             // Past saturation
            presentBranch(32'h0000_2000, 32'h0000_0020);
            resolveHead(1'b0);
        end
        presentBranch(32'h0000_2000, 32'h0000_0020);
        checkEq(predRedirect, 1'b1, "forward after training");
        resolveHead(1'b1);                           // 11 to 10
        presentBranch(32'h0000_2000, 32'h0000_0020);
        checkEq(predRedirect, 1'b1, "forward after one miss");
        resolveHead(1'b1);                           // 10 to 01
        presentBranch(32'h0000_2000, 32'h0000_0020);
        checkEq(predRedirect, 1'b0, "forward after two misses");
        resolveHead(1'b0);
    endtask

    task automatic testInFlight();
        presentBranch(32'h0000_4000, 32'h0000_0010);
        presentBranch(32'h0000_5000, -32'sd16);
        presentBranch(32'h0000_6000, 32'h0000_0030);
        resolveHead(1'b0);                           // Oldest first
        resolveHead(1'b1);                           // Squashes the third
        presentBranch(32'h0000_7000, 32'h0000_0010);
        resolveHead(1'b1);                           // Repair from the new branch
    endtask

    task automatic testStall();
        for (int i = 0; i < queueDepth; i++) begin
            presentBranch(32'h0000_8000 + 32'(i * 16), 32'h0000_0040);
        end
        waitStall(1'b1);
        presentBranch(32'h0000_9000, -32'sd8);       // Dropped while stalled
        checkEq(predRedirect, 1'b0, "branch during stall");
        resolveHead(1'b0);
        waitStall(1'b0);
        drainQueue();
    endtask

    task automatic testRandomTargets();
        addrT r;
        addrT pc;
        addrT off;
        for (int i = 0; i < 8; i++) begin
            r   = $random(seed);
            pc  = $random(seed);
            pc[1:0] = 2'b00;
            r[12]   = i[0];                          // Alternate signs
            off = {{19{r[12]}}, r[12:1], 1'b0};
            presentBranch(pc, off);
            resolveHead(!modelQ[0].predTaken);       // Always taken, target seen
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        pcF          = '0;
        instr        = '0;
        instrValid   = 1'b0;
        resolveValid = 1'b0;
        actualTaken  = 1'b0;
        errors       = 0;
        checks       = 0;
        seed         = 32'h7603_d0a0;
        modelFwd     = 2'b01;
        modelBwd     = 2'b10;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        testAfterReset();
        testResolve();
        testTraining();
        testInFlight();
        testStall();
        testRandomTargets();
        repeat (2) @(posedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: testbench/bpuTop_checker.sv
`timescale 1ns/1ns

module bpuTop_checker
    import bpuPkg::*;
(
    input logic clk,
    input logic rstN,
    input logic resolveValid, // Outcome strobe from execute
    input logic empty,        // Queue holds no branch
    input logic flush,
    input logic predRedirect,
    input addrT pcRedirect
);

    // Mispredict repair is a single-cycle strobe
    flushOnePulse: assert property (
        @(posedge clk) disable iff (!rstN) flush |=> !flush
    ) else $error("flush stayed high for more than one cycle");

    // Execute only resolves branches that were recorded
    noResolveEmpty: assert property (
        @(posedge clk) disable iff (!rstN) resolveValid |-> !empty
    ) else $error("resolve arrived while the branch queue was empty");

    // Repair wins, so both strobes never coincide
    oneRedirect: assert property (
        @(posedge clk) disable iff (!rstN) !(predRedirect && flush)
    ) else $error("predRedirect and flush high together");

    // Redirect address must be driven when used
    pcKnown: assert property (
        @(posedge clk) disable iff (!rstN) (predRedirect || flush) |-> !$isunknown(pcRedirect)
    ) else $error("pcRedirect unknown during a redirect");

endmodule

bind bpuTop bpuTop_checker chk0 (
    .clk          (clk),
    .rstN         (rstN),
    .resolveValid (resolveValid),
    .empty        (empty),
    .flush        (flush),
    .predRedirect (predRedirect),
    .pcRedirect   (pcRedirect)
);

// File: verilog/bpuPkg.sv
package bpuPkg;

    // Widths with a meaning
    typedef logic [31:0] addrT;  // Instruction address
    typedef logic [31:0] instrT; // Raw instruction word
    typedef logic [1:0]  ctrT;   // 2-bit saturating counter

    // RV32I B-type major opcode
    localparam logic [6:0] opcodeBranch = 7'b1100011;

    // Reserved funct3 codes inside the branch opcode
    localparam logic [2:0] funct3Rsvd0 = 3'b010;
    localparam logic [2:0] funct3Rsvd1 = 3'b011;

    // Counter reset values
    localparam ctrT fwdCtrReset = 2'b01; // Weakly not taken
    localparam ctrT bwdCtrReset = 2'b10; // Weakly taken

    // Saturation limits
    localparam ctrT ctrMax = 2'b11;
    localparam ctrT ctrMin = 2'b00;

    // Decode result, 66 bits
    typedef struct packed {
        logic isBranch;    // Valid B-type instruction
        addrT target;      // pc + B immediate
        addrT fallThrough; // pc + 4
        logic backward;    // Immediate sign
    } decodeT;

    // In-flight branch record, 66 bits
    typedef struct packed {
        addrT fallThrough; // Repair PC if not taken
        addrT target;      // Repair PC if taken
        logic backward;    // Selects the counter to train
        logic predTaken;   // What fetch was told
    } branchRecT;

    // Counter training request
    typedef struct packed {
        logic backward; // Which counter
        logic correct;  // Step up when set, else down
    } updateT;

endpackage

// File: verilog/bpuTop.sv
`timescale 1ns/1ns

module bpuTop
    import bpuPkg::*;
#(
    parameter int queueDepth = 4 // In-flight branches, power of two
)(
    input  logic  clk,
    input  logic  rstN,
    input  addrT  pcF,
    input  instrT instr,
    input  logic  instrValid,
    input  logic  resolveValid,
    input  logic  actualTaken,
    output logic  stallFetch,
    output logic  predRedirect,
    output logic  flush,
    output addrT  pcRedirect
);

    decodeT    dec;         // Decode of the fetched word
    logic      predTaken;   // Counter verdict for it
    logic      pushValid;   // Record enters queue
    branchRecT pushRec;
    logic      popValid;    // Head retires
    logic      clear;       // Mispredict squash
    branchRecT headRec;     // Oldest unresolved branch
    logic      empty;
    logic      full;
    logic      updateValid; // Counter training strobe
    updateT    update;

    branchTargetCalc btc0 (
        .pc    (pcF),
        .instr (instr),
        .dec   (dec)
    );

    directionPredictor dp0 (
        .clk         (clk),
        .rstN        (rstN),
        .backward    (dec.backward),
        .predTaken   (predTaken),
        .updateValid (updateValid),
        .update      (update)
    );

    branchHistoryQueue #(
        .queueDepth (queueDepth)
    ) bhq0 (
        .clk       (clk),
        .rstN      (rstN),
        .pushValid (pushValid),
        .pushRec   (pushRec),
        .popValid  (popValid),
        .clear     (clear),
        .headRec   (headRec),
        .empty     (empty),
        .full      (full)
    );

    redirectArbiter arb0 (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .dec          (dec),
        .predTaken    (predTaken),
        .resolveValid (resolveValid),
        .actualTaken  (actualTaken),
        .headRec      (headRec),
        .empty        (empty),
        .full         (full),
        .pushValid    (pushValid),
        .pushRec      (pushRec),
        .popValid     (popValid),
        .clear        (clear),
        .updateValid  (updateValid),
        .update       (update),
        .flush        (flush),
        .predRedirect (predRedirect),
        .pcRedirect   (pcRedirect),
        .stallFetch   (stallFetch)
    );

endmodule

// File: verilog/branchHistoryQueue.sv
`timescale 1ns/1ns

module branchHistoryQueue
    import bpuPkg::*;
#(
    parameter int queueDepth = 4
)(
    input  logic      clk,
    input  logic      rstN,
    input  logic      pushValid,
    input  branchRecT pushRec,
    input  logic      popValid,
    input  logic      clear,
    output branchRecT headRec,
    output logic      empty,
    output logic      full
);

    localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntW = $clog2(queueDepth + 1);

    typedef logic [ptrW-1:0] ptrT; // Slot index
    typedef logic [cntW-1:0] cntT; // Occupancy, 0 to queueDepth

    branchRecT mem [queueDepth]; // Record storage
    ptrT       wrPtr;            // Next free slot
    ptrT       rdPtr;            // Oldest record
    cntT       count;            // Records held
    logic      doPush;           // Write this edge
    logic      doPop;            // Retire head this edge

    // Full only blocks a push when nothing leaves on the same edge
    assign doPush = pushValid && !clear && (!full || popValid);
    assign doPop  = popValid && !clear && !empty;

    assign empty   = (count == cntT'(0));
    assign full    = (count == cntT'(queueDepth));
    assign headRec = mem[rdPtr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            wrPtr <= '0; // Squash everything in flight
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= ptrT'(wrPtr + 1'b1); // Power-of-two wrap
            end
            if (doPop) begin
                rdPtr <= ptrT'(rdPtr + 1'b1);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + cntT'(1);
                2'b01:   count <= count - cntT'(1);
                default: count <= count;      // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushRec;
        end
    end

endmodule

// File: verilog/branchTargetCalc.sv
`timescale 1ns/1ns

module branchTargetCalc
    import bpuPkg::*;
(
    input  addrT   pc,
    input  instrT  instr,
    output decodeT dec
);

    logic [6:0] opcode;  // Major opcode field
    logic [2:0] funct3;  // Compare type
    logic       opMatch; // Opcode says branch
    logic       f3Legal; // funct3 is a defined compare
    addrT       immB;    // Sign-extended B immediate

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign opMatch = (opcode == opcodeBranch);
    assign f3Legal = (funct3 != funct3Rsvd0) && (funct3 != funct3Rsvd1); // 010 and 011 undefined

    // imm[12|10:5] in 31:25, imm[4:1|11] in 11:7, bit 0 always zero
    assign immB = {
        {19{instr[31]}}, // Sign extension
        instr[31],       // imm[12]
        instr[7],        // imm[11]
        instr[30:25],    // imm[10:5]
        instr[11:8],     // imm[4:1]
        1'b0             // Halfword aligned
    };

    always_comb begin
        dec             = '0;
        dec.isBranch    = opMatch && f3Legal;
        dec.target      = pc + immB;   // Wraps mod 2^32
        dec.fallThrough = pc + 32'd4;  // Next sequential
        dec.backward    = instr[31];   // Negative offset means loop
    end

endmodule

// File: verilog/directionPredictor.sv
`timescale 1ns/1ns

module directionPredictor
    import bpuPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   backward,
    output logic   predTaken,
    input  logic   updateValid,
    input  updateT update
);

    ctrT fwdCtr;  // Forward branch counter
    ctrT bwdCtr;  // Backward branch counter
    ctrT predCtr; // Counter for the branch in decode

    // One saturating step
    function automatic ctrT satStep(input ctrT cur, input logic up);
        ctrT nxt;
        nxt = cur;
        if (up) begin
            if (cur != ctrMax) begin
                nxt = cur + 2'd1;
            end
        end else begin
            if (cur != ctrMin) begin
                nxt = cur - 2'd1;
            end
        end
        return nxt;
    endfunction

    assign predCtr   = backward ? bwdCtr : fwdCtr;
    assign predTaken = predCtr[1]; // 10 and 11 predict taken

    // Forward counter training
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fwdCtr <= fwdCtrReset;
        end else if (updateValid && !update.backward) begin
            fwdCtr <= satStep(fwdCtr, update.correct);
        end
    end

    // Backward counter training
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bwdCtr <= bwdCtrReset;
        end else if (updateValid && update.backward) begin
            bwdCtr <= satStep(bwdCtr, update.correct);
        end
    end

endmodule

// File: verilog/redirectArbiter.sv
`timescale 1ns/1ns

module redirectArbiter
    import bpuPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      instrValid,
    input  decodeT    dec,
    input  logic      predTaken,
    input  logic      resolveValid,
    input  logic      actualTaken,
    input  branchRecT headRec,
    input  logic      empty,
    input  logic      full,
    output logic      pushValid,
    output branchRecT pushRec,
    output logic      popValid,
    output logic      clear,
    output logic      updateValid,
    output updateT    update,
    output logic      flush,
    output logic      predRedirect,
    output addrT      pcRedirect,
    output logic      stallFetch
);

    logic mispredict; // Head outcome differs from prediction
    logic acceptBr;   // Branch gets predicted and recorded
    logic takeRedir;  // Accepted and predicted taken

    // Queue and counter control act on the sampling edge
    assign popValid   = resolveValid && !empty;     // Resolve on empty is ignored
    assign mispredict = popValid && (actualTaken != headRec.predTaken);
    assign clear      = mispredict;                 // Younger entries are wrong path

    // Wrong-path, stalled or overflowing branches are dropped
    assign acceptBr  = instrValid && dec.isBranch && !stallFetch && !mispredict
                       && (!full || popValid);
    assign takeRedir = acceptBr && predTaken;

    assign pushValid = acceptBr;
    assign pushRec   = '{fallThrough: dec.fallThrough, target: dec.target,
                         backward: dec.backward, predTaken: predTaken};

    assign updateValid    = popValid;
    assign update.backward = headRec.backward;
    assign update.correct  = !mispredict;

    // Fetch-facing strobes, one cycle after the sampling edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flush        <= 1'b0;
            predRedirect <= 1'b0;
            stallFetch   <= 1'b0;
        end else begin
            flush        <= mispredict;
            predRedirect <= takeRedir; // Never with mispredict
            stallFetch   <= full;
        end
    end

    // Repair PC wins over predicted target
    always_ff @(posedge clk) begin
        if (mispredict) begin
            pcRedirect <= actualTaken ? headRec.target : headRec.fallThrough;
        end else if (takeRedir) begin
            pcRedirect <= dec.target;
        end
    end

endmodule
